// File: mem_subsys.f
rtl/core_pkg.sv
rtl/mem_pkg.sv
rtl/memory_stage.sv
rtl/fetch_unit.sv
rtl/mem_arbiter.sv
rtl/data_memory.sv
rtl/mem_subsys.sv
tb/tb_clock.sv
tb/mem_subsys_assert.sv
tb/mem_subsys_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mem_subsys_tb
FILELIST  = mem_subsys.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/mem_subsys_tb.sv
module mem_subsys_tb;
	import core_pkg::*;

	localparam int READ_LATENCY = 2;
	// init, directed, fetch mix and random ops.
	localparam int NUM_OPS = 32 + 4 + 2 + 16 + 17 + 40 + 12 + 200;
	localparam int TIMEOUT = NUM_OPS * (8 + 2 * READ_LATENCY) * 20 + 4000;

	logic        clk;
	logic        rst;
	logic [31:0] reg_pc;
	logic [31:0] rs2_data;
	logic [31:0] alu_out;
	mem_op_t     mem_wen;
	wb_sel_t     wb_sel;
	logic [31:0] read_data;
	logic [31:0] out_reg_pc;
	logic [31:0] out_alu_out;
	wb_sel_t     out_wb_sel;
	logic        next_flg;
	logic        fetch_req;
	logic [31:0] fetch_pc;
	logic [31:0] instr;
	logic        instr_valid;

	integer      seed = 56278;
	int          error_count = 0;
	logic [31:0] shadow [256];
	logic [31:0] exp_read_data;
	logic [31:0] exp_pc;
	logic [31:0] exp_alu;
	wb_sel_t     exp_wb;
	logic        exp_check_rd;
	logic        op_pending = 1'b0;
	int          issued = 0;
	int          done = 0;
	logic [31:0] exp_instr;
	logic        fetch_pending = 1'b0;
	int          fetch_issued = 0;
	int          fetch_done = 0;

	tb_clock tb_clock_inst (.clk, .rst);

	mem_subsys #(.MEM_WORDS(256), .READ_LATENCY(READ_LATENCY)) mem_subsys_inst (.*);

	bind mem_arbiter mem_subsys_assert mem_subsys_assert_inst (
		.clk(clk), .rst(rst), .d_cmd_ready(d_cmd_ready), .f_cmd_ready(f_cmd_ready),
		.d_cmd(d_cmd), .f_cmd(f_cmd), .mem_cmd(mem_cmd),
		.mem_rdata_valid(mem_rdata_valid), .owner(owner)
	);

	task automatic report_failure(input string why);
		error_count++;
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_wb(input string name, input wb_sel_t got, input wb_sel_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_op_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// returns {load value, updated word} by the ISA rules.
	function automatic logic [63:0] ref_access(input mem_op_t op, input logic [31:0] a,
		input logic [31:0] rs2, input logic [31:0] word);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] ld;
		logic [31:0] nw;
		b  = word[8*a[1:0] +: 8];
		h  = a[1] ? word[31:16] : word[15:0];
		ld = 32'hffff_ffff;
		nw = word;
		case (op)
			MEN_LB:  ld = {{24{b[7]}}, b};
			MEN_LBU: ld = {24'h0, b};
			MEN_LH:  ld = {{16{h[15]}}, h};
			MEN_LHU: ld = {16'h0, h};
			MEN_LW:  ld = word;
			MEN_SB:  nw[8*a[1:0] +: 8] = rs2[7:0];
			MEN_SH:  nw[16*a[1] +: 16] = rs2[15:0];
			MEN_SW:  nw = rs2;
			default: ld = 32'hffff_ffff;
		endcase
		return {ld, nw};
	endfunction

	function automatic wb_sel_t pick_wb(input logic [31:0] n);
		case (n % 5)
			0: return WB_X;
			1: return WB_ALU;
			2: return WB_MEM;
			3: return WB_PC;
			default: return WB_CSR;
		endcase
	endfunction

	// called at a falling edge, returns at a falling edge.
	task automatic run_op(input mem_op_t op, input logic [31:0] a, input logic [31:0] rs2);
		logic [63:0] r;
		r             = ref_access(op, a, rs2, shadow[a[9:2]]);
		exp_read_data = r[63:32];
		shadow[a[9:2]] = r[31:0];
		exp_check_rd  = !(op == MEN_SB || op == MEN_SH || op == MEN_SW);
		exp_pc        = $random(seed);
		exp_alu       = a;
		exp_wb        = pick_wb($unsigned($random(seed)));
		reg_pc        = exp_pc;
		alu_out       = a;
		rs2_data      = rs2;
		mem_wen       = op;
		wb_sel        = exp_wb;
		op_pending    = 1'b1;
		issued++;
		#1;
		check_op_flag("next_flg", next_flg, op == MEN_X);
		wait (done == issued);
		// bubble until the next op arrives.
		mem_wen = MEN_X;
	endtask

	task automatic run_fetch(input logic [31:0] a);
		@(negedge clk);
		while (fetch_pending)
			@(negedge clk);
		exp_instr     = shadow[a[9:2]];
		fetch_pc      = a;
		fetch_req     = 1'b1;
		fetch_pending = 1'b1;
		fetch_issued++;
		@(negedge clk);
		fetch_req = 1'b0;
	endtask

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	// data result compare.
	always @(posedge clk) begin
		if (!rst && op_pending && next_flg) begin
			op_pending = 1'b0;
			@(negedge clk);
			if (exp_check_rd)
				check_word("read_data", read_data, exp_read_data);
			check_word("out_reg_pc", out_reg_pc, exp_pc);
			check_word("out_alu_out", out_alu_out, exp_alu);
			check_wb("out_wb_sel", out_wb_sel, exp_wb);
			done++;
		end
	end

	// fetch result compare.
	always @(negedge clk) begin
		if (!rst && instr_valid) begin
			check_op_flag("instr_valid", instr_valid, fetch_pending);
			check_word("instr", instr, exp_instr);
			fetch_pending = 1'b0;
			fetch_done++;
		end
	end

	initial begin
		#(TIMEOUT);
		$display("timeout: the DUT stopped answering before all operations finished");
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	initial begin
		logic [31:0] a;
		logic [31:0] v;
		logic [31:0] fv;
		reg_pc    = 32'h0;
		rs2_data  = 32'h0;
		alu_out   = 32'h0;
		mem_wen   = MEN_X;
		wb_sel    = WB_X;
		fetch_req = 1'b0;
		fetch_pc  = 32'h0;
		@(negedge clk);
		while (rst)
			@(negedge clk);

		// data region at 0x100, fetch region at 0x200.
		for (int w = 0; w < 16; w++) begin
			a = 32'h100 + 32'(w * 4);
			run_op(MEN_SW, a, fill_word(a));
			a = 32'h200 + 32'(w * 4);
			run_op(MEN_SW, a, fill_word(a));
		end
		for (int i = 0; i < 4; i++)
			run_op(MEN_X, $random(seed), $random(seed));

		run_op(MEN_SW, 32'h104, 32'hc0de_1234);
		run_op(MEN_LW, 32'h104, 32'h0);

		for (int off = 0; off < 4; off++) begin
			run_op(MEN_SB, 32'h108 + 32'(off), $random(seed));
			run_op(MEN_LW, 32'h108, 32'h0);
			run_op(MEN_SH, 32'h10c + 32'(off), $random(seed));
			run_op(MEN_LW, 32'h10c, 32'h0);
		end

		// bytes f0 and 8f negative, halfword 8f7e negative.
		run_op(MEN_SW, 32'h114, 32'h8f7e_01f0);
		for (int off = 0; off < 4; off++) begin
			run_op(MEN_LB, 32'h114 + 32'(off), 32'h0);
			run_op(MEN_LBU, 32'h114 + 32'(off), 32'h0);
			run_op(MEN_LH, 32'h114 + 32'(off), 32'h0);
			run_op(MEN_LHU, 32'h114 + 32'(off), 32'h0);
		end

		fork
			for (int i = 0; i < 40; i++) begin
				v = $unsigned($random(seed));
				run_op(mem_op_t'(v % 9), 32'h100 + (v[15:8] % 64), $random(seed));
			end
			for (int i = 0; i < 12; i++) begin
				fv = $unsigned($random(seed));
				repeat (fv % 4) @(negedge clk);
				run_fetch(32'h200 + 32'((fv[11:8] % 16) * 4));
			end
		join
		@(negedge clk);
		while (fetch_pending)
			@(negedge clk);
		check_word("fetch_done", fetch_done, fetch_issued);

		for (int i = 0; i < 200; i++) begin
			v = $unsigned($random(seed));
			run_op(mem_op_t'(v % 9), 32'h100 + (v[15:8] % 64), $random(seed));
		end

		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: tb/mem_subsys_assert.sv
module mem_subsys_assert (
	input logic              clk,
	input logic              rst,
	input logic              d_cmd_ready,
	input logic              f_cmd_ready,
	input mem_pkg::mem_cmd_t d_cmd,
	input mem_pkg::mem_cmd_t f_cmd,
	input mem_pkg::mem_cmd_t mem_cmd,
	input logic              mem_rdata_valid,
	input mem_pkg::master_t  owner
);
	import mem_pkg::*;

	logic    read_open;
	master_t read_owner;

	// a read stays open until its data returns.
	always_ff @(posedge clk) begin
		if (rst)
			read_open <= 1'b0;
		else if (mem_cmd == CMD_READ)
			read_open <= 1'b1;
		else if (mem_rdata_valid)
			read_open <= 1'b0;
	end

	// master that issued the outstanding read.
	always_ff @(posedge clk) begin
		if (mem_cmd == CMD_READ)
			read_owner <= owner;
	end

	one_offer: assert property (@(posedge clk) disable iff (rst)
		!(d_cmd_ready && f_cmd_ready))
		else $error("both masters offered a slot at once");

	d_slot: assert property (@(posedge clk) disable iff (rst)
		(d_cmd != CMD_NONE) |-> $past(d_cmd_ready))
		else $error("data command outside its slot");

	f_slot: assert property (@(posedge clk) disable iff (rst)
		(f_cmd != CMD_NONE) |-> $past(f_cmd_ready))
		else $error("fetch command outside its slot");

	valid_open: assert property (@(posedge clk) disable iff (rst)
		mem_rdata_valid |-> read_open)
		else $error("read data valid with no read outstanding");

	valid_owner: assert property (@(posedge clk) disable iff (rst)
		mem_rdata_valid |-> (owner == read_owner))
		else $error("read data returned while another master owns the bus");

endmodule

// File: tb/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held over two rising edges.
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: rtl/mem_subsys.sv
module mem_subsys #(
	parameter int MEM_WORDS    = 256,
	parameter int READ_LATENCY = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [31:0]       reg_pc,
	input  logic [31:0]       rs2_data,
	input  logic [31:0]       alu_out,
	input  core_pkg::mem_op_t mem_wen,
	input  core_pkg::wb_sel_t wb_sel,
	output logic [31:0]       read_data,
	output logic [31:0]       out_reg_pc,
	output logic [31:0]       out_alu_out,
	output core_pkg::wb_sel_t out_wb_sel,
	output logic              next_flg,
	input  logic              fetch_req,
	input  logic [31:0]       fetch_pc,
	output logic [31:0]       instr,
	output logic              instr_valid
);
	import mem_pkg::*;

	mem_cmd_t    d_cmd;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;
	logic [31:0] d_wmask;
	logic        d_cmd_ready;
	logic [31:0] d_rdata;
	logic        d_rdata_valid;

	mem_cmd_t    f_cmd;
	logic [31:0] f_addr;
	logic [31:0] f_wdata;
	logic [31:0] f_wmask;
	logic        f_cmd_ready;
	logic [31:0] f_rdata;
	logic        f_rdata_valid;

	mem_cmd_t    mem_cmd;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [31:0] mem_wmask;
	logic [31:0] mem_rdata;
	logic        mem_rdata_valid;

	memory_stage memory_stage_inst (
		.clk, .rst,
		.reg_pc, .rs2_data, .alu_out, .mem_wen, .wb_sel,
		.cmd_ready(d_cmd_ready), .rdata(d_rdata), .rdata_valid(d_rdata_valid),
		.read_data, .out_reg_pc, .out_alu_out, .out_wb_sel, .next_flg,
		.cmd(d_cmd), .addr(d_addr), .wdata(d_wdata), .wmask(d_wmask)
	);

	fetch_unit fetch_unit_inst (
		.clk, .rst,
		.fetch_req, .fetch_pc,
		.cmd_ready(f_cmd_ready), .rdata(f_rdata), .rdata_valid(f_rdata_valid),
		.instr, .instr_valid,
		.cmd(f_cmd), .addr(f_addr), .wdata(f_wdata), .wmask(f_wmask)
	);

	mem_arbiter mem_arbiter_inst (
		.clk, .rst,
		.d_cmd, .d_addr, .d_wdata, .d_wmask, .d_cmd_ready, .d_rdata, .d_rdata_valid,
		.f_cmd, .f_addr, .f_wdata, .f_wmask, .f_cmd_ready, .f_rdata, .f_rdata_valid,
		.mem_cmd, .mem_addr, .mem_wdata, .mem_wmask, .mem_rdata, .mem_rdata_valid
	);

	data_memory #(
		.MEM_WORDS(MEM_WORDS),
		.READ_LATENCY(READ_LATENCY)
	) data_memory_inst (
		.clk, .rst,
		.mem_cmd, .mem_addr, .mem_wdata, .mem_wmask, .mem_rdata, .mem_rdata_valid
	);

endmodule

// File: rtl/data_memory.sv
module data_memory #(
	parameter int MEM_WORDS    = 256,
	parameter int READ_LATENCY = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_cmd_t mem_cmd,
	input  logic [31:0]       mem_addr,
	input  logic [31:0]       mem_wdata,
	input  logic [31:0]       mem_wmask,
	output logic [31:0]       mem_rdata,
	output logic              mem_rdata_valid
);
	import mem_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [31:0]      mem [MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [31:0]      data_pipe [READ_LATENCY];
	logic             valid_pipe [READ_LATENCY];

	// word index wraps at the array depth.
	assign idx = IDX_W'(mem_addr[31:2] % MEM_WORDS);

	always_ff @(posedge clk) begin
		if (mem_cmd == CMD_WRITE)
			mem[idx] <= (mem[idx] & ~mem_wmask) | (mem_wdata & mem_wmask);
	end

	// read data delay line.
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[idx];
		for (int i = 1; i < READ_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < READ_LATENCY; i++) begin
				valid_pipe[i] <= 1'b0;
			end
		end else begin
			valid_pipe[0] <= (mem_cmd == CMD_READ);
			for (int i = 1; i < READ_LATENCY; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	assign mem_rdata       = data_pipe[READ_LATENCY-1];
	assign mem_rdata_valid = valid_pipe[READ_LATENCY-1];

endmodule

// File: rtl/mem_arbiter.sv
module mem_arbiter (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::mem_cmd_t d_cmd,
	input  logic [31:0]       d_addr,
	input  logic [31:0]       d_wdata,
	input  logic [31:0]       d_wmask,
	output logic              d_cmd_ready,
	output logic [31:0]       d_rdata,
	output logic              d_rdata_valid,
	input  mem_pkg::mem_cmd_t f_cmd,
	input  logic [31:0]       f_addr,
	input  logic [31:0]       f_wdata,
	input  logic [31:0]       f_wmask,
	output logic              f_cmd_ready,
	output logic [31:0]       f_rdata,
	output logic              f_rdata_valid,
	output mem_pkg::mem_cmd_t mem_cmd,
	output logic [31:0]       mem_addr,
	output logic [31:0]       mem_wdata,
	output logic [31:0]       mem_wmask,
	input  logic [31:0]       mem_rdata,
	input  logic              mem_rdata_valid
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		A_IDLE,
		A_OFFER,
		A_SLOT,
		A_BUSY
	} arb_state_t;

	arb_state_t state;
	master_t    owner;
	master_t    other;
	mem_cmd_t   slot_cmd;

	assign other    = (owner == M_DATA) ? M_FETCH : M_DATA;
	assign slot_cmd = (owner == M_DATA) ? d_cmd : f_cmd;

	assign d_cmd_ready = (state == A_OFFER) && (owner == M_DATA);
	assign f_cmd_ready = (state == A_OFFER) && (owner == M_FETCH);

	// owner's command goes straight through in its slot.
	assign mem_cmd   = (state == A_SLOT) ? slot_cmd : CMD_NONE;
	assign mem_addr  = (owner == M_DATA) ? d_addr : f_addr;
	assign mem_wdata = (owner == M_DATA) ? d_wdata : f_wdata;
	assign mem_wmask = (owner == M_DATA) ? d_wmask : f_wmask;

	assign d_rdata       = mem_rdata;
	assign f_rdata       = mem_rdata;
	assign d_rdata_valid = mem_rdata_valid && (state == A_BUSY) && (owner == M_DATA);
	assign f_rdata_valid = mem_rdata_valid && (state == A_BUSY) && (owner == M_FETCH);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= A_IDLE;
			owner <= M_DATA;
		end else begin
			case (state)
				A_IDLE:  state <= A_OFFER;
				A_OFFER: state <= A_SLOT;
				A_SLOT: begin
					if (slot_cmd == CMD_READ) begin
						state <= A_BUSY;
					end else begin
						// write done on acceptance, or slot left empty.
						state <= A_OFFER;
						owner <= other;
					end
				end
				default: begin
					if (mem_rdata_valid) begin
						state <= A_OFFER;
						owner <= other;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/fetch_unit.sv
module fetch_unit (
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_req,
	input  logic [31:0]       fetch_pc,
	input  logic              cmd_ready,
	input  logic [31:0]       rdata,
	input  logic              rdata_valid,
	output logic [31:0]       instr,
	output logic              instr_valid,
	output mem_pkg::mem_cmd_t cmd,
	output logic [31:0]       addr,
	output logic [31:0]       wdata,
	output logic [31:0]       wmask
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE,
		F_WAIT_READY,
		F_ISSUE,
		F_WAIT_READ
	} fetch_state_t;

	fetch_state_t state;
	logic [31:0]  pc_q;

	assign cmd   = (state == F_ISSUE) ? CMD_READ : CMD_NONE;
	assign addr  = {pc_q[31:2], 2'b00};
	assign wdata = 32'b0;
	assign wmask = 32'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= F_IDLE;
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= 1'b0;
			case (state)
				F_IDLE: begin
					if (fetch_req)
						state <= F_WAIT_READY;
				end
				F_WAIT_READY: begin
					if (cmd_ready)
						state <= F_ISSUE;
				end
				F_ISSUE: state <= F_WAIT_READ;
				default: begin
					if (rdata_valid) begin
						instr_valid <= 1'b1;
						state       <= F_IDLE;
					end
				end
			endcase
		end
	end

	// requests outside idle are dropped.
	always_ff @(posedge clk) begin
		if ((state == F_IDLE) && fetch_req)
			pc_q <= fetch_pc;
		if ((state == F_WAIT_READ) && rdata_valid)
			instr <= rdata;
	end

endmodule

// File: rtl/memory_stage.sv
module memory_stage (
	input  logic              clk,
	input  logic              rst,
	input  logic [31:0]       reg_pc,
	input  logic [31:0]       rs2_data,
	input  logic [31:0]       alu_out,
	input  core_pkg::mem_op_t mem_wen,
	input  core_pkg::wb_sel_t wb_sel,
	input  logic              cmd_ready,
	input  logic [31:0]       rdata,
	input  logic              rdata_valid,
	output logic [31:0]       read_data,
	output logic [31:0]       out_reg_pc,
	output logic [31:0]       out_alu_out,
	output core_pkg::wb_sel_t out_wb_sel,
	output logic              next_flg,
	output mem_pkg::mem_cmd_t cmd,
	output logic [31:0]       addr,
	output logic [31:0]       wdata,
	output logic [31:0]       wmask
);
	import core_pkg::*;
	import mem_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_READY,
		S_ISSUE,
		S_WAIT_READ,
		S_END
	} state_t;

	state_t      state;
	logic [31:0] save_reg_pc;
	logic [31:0] save_alu_out;
	logic [31:0] save_rs2_data;
	mem_op_t     save_mem_wen;
	wb_sel_t     save_wb_sel;
	logic        is_store;
	logic [4:0]  lane_shift;
	logic [31:0] store_mask;
	logic [31:0] lane_data;
	logic [31:0] load_value;

	assign is_store = (save_mem_wen == MEN_SB) || (save_mem_wen == MEN_SH) ||
		(save_mem_wen == MEN_SW);

	// halfwords only look at address bit 1.
	always_comb begin
		case (save_mem_wen)
			MEN_SB, MEN_LB, MEN_LBU: lane_shift = {save_alu_out[1:0], 3'b000};
			MEN_SH, MEN_LH, MEN_LHU: lane_shift = {save_alu_out[1], 4'b0000};
			default:                 lane_shift = 5'd0;
		endcase
	end

	always_comb begin
		case (save_mem_wen)
			MEN_SB:  store_mask = 32'h0000_00ff;
			MEN_SH:  store_mask = 32'h0000_ffff;
			default: store_mask = 32'hffff_ffff;
		endcase
	end

	assign lane_data = rdata >> lane_shift;

	always_comb begin
		case (save_mem_wen)
			MEN_LB:  load_value = {{24{lane_data[7]}}, lane_data[7:0]};
			MEN_LBU: load_value = {24'b0, lane_data[7:0]};
			MEN_LH:  load_value = {{16{lane_data[15]}}, lane_data[15:0]};
			MEN_LHU: load_value = {16'b0, lane_data[15:0]};
			default: load_value = rdata;
		endcase
	end

	assign next_flg = ((state == S_IDLE) && (mem_wen == MEN_X)) || (state == S_END);

	assign cmd   = (state == S_ISSUE) ? (is_store ? CMD_WRITE : CMD_READ) : CMD_NONE;
	assign addr  = {save_alu_out[31:2], 2'b00};
	assign wdata = save_rs2_data << lane_shift;
	assign wmask = store_mask << lane_shift;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (mem_wen != MEN_X)
						state <= S_WAIT_READY;
				end
				S_WAIT_READY: begin
					if (cmd_ready)
						state <= S_ISSUE;
				end
				S_ISSUE:     state <= is_store ? S_END : S_WAIT_READ;
				S_WAIT_READ: begin
					if (rdata_valid)
						state <= S_END;
				end
				default:     state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (mem_wen != MEN_X) begin
					save_reg_pc   <= reg_pc;
					save_alu_out  <= alu_out;
					save_rs2_data <= rs2_data;
					save_mem_wen  <= mem_wen;
					save_wb_sel   <= wb_sel;
				end else begin
					read_data   <= 32'hffff_ffff;
					out_reg_pc  <= reg_pc;
					out_alu_out <= alu_out;
					out_wb_sel  <= wb_sel;
				end
			end
			S_WAIT_READ: begin
				if (rdata_valid)
					read_data <= load_value;
			end
			S_END: begin
				out_reg_pc  <= save_reg_pc;
				out_alu_out <= save_alu_out;
				out_wb_sel  <= save_wb_sel;
			end
			default: ;
		endcase
	end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

	// command on the shared bus.
	typedef enum logic [2:0] {
		CMD_NONE  = 3'd0,
		CMD_READ  = 3'd1,
		CMD_WRITE = 3'd2
	} mem_cmd_t;

	// owner of the current arbiter slot.
	typedef enum logic {
		M_DATA  = 1'b0,
		M_FETCH = 1'b1
	} master_t;

endpackage

// File: rtl/core_pkg.sv
package core_pkg;

	// memory access kind handed over by execute.
	typedef enum logic [4:0] {
		MEN_X   = 5'd0,
		MEN_LB  = 5'd1,
		MEN_LH  = 5'd2,
		MEN_LW  = 5'd3,
		MEN_LBU = 5'd4,
		MEN_LHU = 5'd5,
		MEN_SB  = 5'd6,
		MEN_SH  = 5'd7,
		MEN_SW  = 5'd8
	} mem_op_t;

	// writeback source, carried through the memory stage.
	typedef enum logic [3:0] {
		WB_X   = 4'd0,
		WB_ALU = 4'd1,
		WB_MEM = 4'd2,
		WB_PC  = 4'd3,
		WB_CSR = 4'd4
	} wb_sel_t;

endpackage
